// ==== project.f ====
src/seg_geom_pkg.sv
src/seg_score_pkg.sv
src/pixel_ram.sv
src/max_pool.sv
src/class_argmax.sv
src/label_unpool.sv
src/seg_top.sv
testbench/seg_asserts.sv
testbench/seg_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module seg_tb -f project.f -o seg_sim

output="$(./obj_dir/seg_sim 2>&1)" || true
echo "$output"

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi

// ==== src/class_argmax.sv ====
// Fixed three-cycle latency, four classes only; ties resolve to the higher class index
`default_nettype none

module class_argmax (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      pool_valid,
    input  wire seg_score_pkg::score_vec_t pool_scores,
    input  wire seg_geom_pkg::vcnt_t       pool_bv,
    input  wire seg_geom_pkg::hcnt_t       pool_bh,
    output logic                           block_valid,
    output seg_score_pkg::label_t          block_label,
    output seg_geom_pkg::vcnt_t            block_bv,
    output seg_geom_pkg::hcnt_t            block_bh
);

    seg_score_pkg::score_t a, b, c, d;
    seg_score_pkg::score_t more0, more1;
    seg_score_pkg::label_t win0, win1;
    logic                  s1_valid, s2_valid;
    seg_geom_pkg::vcnt_t   s1_bv, s2_bv;
    seg_geom_pkg::hcnt_t   s1_bh, s2_bh;

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid    <= 1'b0;
            s2_valid    <= 1'b0;
            block_valid <= 1'b0;
        end else begin
            s1_valid    <= pool_valid;
            s2_valid    <= s1_valid;
            block_valid <= s2_valid;
        end
    end

    always_ff @(posedge clock) begin
        // Stage 1
        a     <= pool_scores[0];
        b     <= pool_scores[1];
        c     <= pool_scores[2];
        d     <= pool_scores[3];
        s1_bv <= pool_bv;
        s1_bh <= pool_bh;

        // Stage 2 compares the pairs
        more0 <= (a > b) ? a : b;
        win0  <= (a > b) ? seg_score_pkg::label_t'(0) : seg_score_pkg::label_t'(1);
        more1 <= (c > d) ? c : d;
        win1  <= (c > d) ? seg_score_pkg::label_t'(2) : seg_score_pkg::label_t'(3);
        s2_bv <= s1_bv;
        s2_bh <= s1_bh;

        // Stage 3 picks between the pair winners
        block_label <= (more0 > more1) ? win0 : win1;
        block_bv    <= s2_bv;
        block_bh    <= s2_bh;
    end

endmodule

`default_nettype wire

// ==== src/label_unpool.sv ====
// Labels lag by one frame; label_valid stays low until the first full frame of blocks is stored
`default_nettype none

module label_unpool #(
    parameter int WIDTH  = 16,
    parameter int HEIGHT = 8
) (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  block_valid,
    input  wire seg_score_pkg::label_t block_label,
    input  wire seg_geom_pkg::vcnt_t   block_bv,
    input  wire seg_geom_pkg::hcnt_t   block_bh,
    input  wire logic                  pixel_valid,
    input  wire seg_geom_pkg::vcnt_t   pixel_vcnt,
    input  wire seg_geom_pkg::hcnt_t   pixel_hcnt,
    output logic                       label_valid,
    output seg_score_pkg::label_t      label,
    output seg_geom_pkg::vcnt_t        label_vcnt,
    output seg_geom_pkg::hcnt_t        label_hcnt
);

    localparam int BLOCKS_W  = WIDTH / 2;
    localparam int BLOCKS_H  = HEIGHT / 2;
    localparam int DEPTH     = BLOCKS_W * BLOCKS_H;
    localparam int ADDR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    function automatic logic [ADDR_BITS-1:0] block_addr(
        input seg_geom_pkg::vcnt_t bv,
        input seg_geom_pkg::hcnt_t bh
    );
        return ADDR_BITS'(int'(bv) * BLOCKS_W + int'(bh));
    endfunction

    logic primed;
    logic last_block;

    assign last_block = block_valid &&
                        block_bv == seg_geom_pkg::vcnt_t'(BLOCKS_H - 1) &&
                        block_bh == seg_geom_pkg::hcnt_t'(BLOCKS_W - 1);

    // Every pixel of a block reads the same entry
    pixel_ram #(
        .word_t (seg_score_pkg::label_t),
        .DEPTH  (DEPTH)
    ) label_store_i (
        .clock        (clock),
        .write_enable (block_valid),
        .write_addr   (block_addr(block_bv, block_bh)),
        .write_data   (block_label),
        .read_addr    (block_addr(pixel_vcnt >> 1, pixel_hcnt >> 1)),
        .read_data    (label)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            primed      <= 1'b0;
            label_valid <= 1'b0;
        end else begin
            if (last_block) begin
                primed <= 1'b1;
            end
            label_valid <= pixel_valid && primed;
        end
    end

    // Line up counters with the read data
    always_ff @(posedge clock) begin
        label_vcnt <= pixel_vcnt;
        label_hcnt <= pixel_hcnt;
    end

endmodule

`default_nettype wire

// ==== src/max_pool.sv ====
// Needs raster order and even WIDTH and HEIGHT; block coordinates come from the input counters
`default_nettype none

module max_pool #(
    parameter int WIDTH  = 16,
    parameter int HEIGHT = 8
) (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      pixel_valid,
    input  wire seg_score_pkg::score_vec_t pixel_scores,
    input  wire seg_geom_pkg::vcnt_t       pixel_vcnt,
    input  wire seg_geom_pkg::hcnt_t       pixel_hcnt,
    output logic                           pool_valid,
    output seg_score_pkg::score_vec_t      pool_scores,
    output seg_geom_pkg::vcnt_t            pool_bv,
    output seg_geom_pkg::hcnt_t            pool_bh
);

    localparam int COLS     = WIDTH / 2;
    localparam int COL_BITS = (COLS > 1) ? $clog2(COLS) : 1;

    if (WIDTH % 2 != 0 || HEIGHT % 2 != 0 ||
        WIDTH > seg_geom_pkg::MAX_WIDTH || HEIGHT > seg_geom_pkg::MAX_HEIGHT) begin : g_bad_size
        $error("max_pool: frame size must be even and within the supported maxima");
    end

    function automatic seg_score_pkg::score_t max_score(
        input seg_score_pkg::score_t a,
        input seg_score_pkg::score_t b
    );
        return (a > b) ? a : b;
    endfunction

    logic [COL_BITS-1:0]       col;
    logic [COL_BITS-1:0]       hold_col;
    seg_score_pkg::score_vec_t hold_scores;
    seg_score_pkg::score_vec_t pair_max;
    seg_score_pkg::score_vec_t row_above;
    seg_score_pkg::score_vec_t block_max;
    logic [COL_BITS-1:0]       read_addr;
    logic                      row_write;
    logic                      block_done;

    assign col        = pixel_hcnt[COL_BITS:1];
    assign row_write  = pixel_valid && !pixel_vcnt[0] && pixel_hcnt[0];
    assign block_done = pixel_valid && pixel_vcnt[0] && pixel_hcnt[0];

    // Keep the address steady across gaps so the row above is ready at the odd column
    assign read_addr = pixel_valid ? col : hold_col;

    // ------------------------------
    // Horizontal pair
    // ------------------------------
    always_ff @(posedge clock) begin
        if (pixel_valid && !pixel_hcnt[0]) begin
            hold_scores <= pixel_scores;
            hold_col    <= col;
        end
    end

    always_comb begin
        for (int c = 0; c < seg_score_pkg::CLASSES; c++) begin
            pair_max[c]  = max_score(hold_scores[c], pixel_scores[c]);
            block_max[c] = max_score(pair_max[c], row_above[c]);
        end
    end

    // Pair maxima of the even row are read back on the odd row
    pixel_ram #(
        .word_t (seg_score_pkg::score_vec_t),
        .DEPTH  (COLS)
    ) row_buf_i (
        .clock        (clock),
        .write_enable (row_write),
        .write_addr   (col),
        .write_data   (pair_max),
        .read_addr    (read_addr),
        .read_data    (row_above)
    );

    // ------------------------------
    // Block output
    // ------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            pool_valid <= 1'b0;
        end else begin
            pool_valid <= block_done;
        end
    end

    always_ff @(posedge clock) begin
        if (block_done) begin
            pool_scores <= block_max;
            pool_bv     <= pixel_vcnt >> 1;
            pool_bh     <= pixel_hcnt >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== src/pixel_ram.sv ====
// No reset on contents; read and write of the same address in one cycle gives undefined data
`default_nettype none

module pixel_ram #(
    parameter type word_t = logic [7:0],
    parameter int  DEPTH  = 16
) (
    input  wire logic                                   clock,
    input  wire logic                                   write_enable,
    input  wire logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] write_addr,
    input  wire word_t                                  write_data,
    input  wire logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] read_addr,
    output word_t                                       read_data
);

    word_t mem [DEPTH];

    // Write port
    always_ff @(posedge clock) begin
        if (write_enable) begin
            mem[write_addr] <= write_data;
        end
    end

    // Read port with one cycle latency
    always_ff @(posedge clock) begin
        read_data <= mem[read_addr];
    end

endmodule

`default_nettype wire

// ==== src/seg_geom_pkg.sv ====
// Frame limits are fixed at 64x64; counters are sized from them, not from the frame in use
`default_nettype none

package seg_geom_pkg;

    // ------------------------------
    // Frame limits
    // ------------------------------

    // Largest frame any instance may be built for
    localparam int MAX_WIDTH  = 64;
    localparam int MAX_HEIGHT = 64;

    localparam int HCNT_BITS = $clog2(MAX_WIDTH);
    localparam int VCNT_BITS = $clog2(MAX_HEIGHT);

    // ------------------------------
    // Counter types
    // ------------------------------

    // Pixel column that also serves block columns
    typedef logic [HCNT_BITS-1:0] hcnt_t;

    // Pixel row that also serves block rows
    typedef logic [VCNT_BITS-1:0] vcnt_t;

endpackage

`default_nettype wire

// ==== src/seg_score_pkg.sv ====
// Four classes and 13-bit signed scores are fixed here; the argmax tree is built for four only
`default_nettype none

package seg_score_pkg;

    // ------------------------------
    // Scores
    // ------------------------------

    // Width of one signed class score
    localparam int SCORE_BITS = 13;

    localparam int CLASSES = 4;

    localparam int LABEL_BITS = $clog2(CLASSES);

    // One signed class score
    typedef logic signed [SCORE_BITS-1:0] score_t;

    // Index c holds the score of class c
    typedef score_t [CLASSES-1:0] score_vec_t;

    // ------------------------------
    // Labels
    // ------------------------------

    // Winning class index
    typedef logic [LABEL_BITS-1:0] label_t;

endpackage

`default_nettype wire

// ==== src/seg_top.sv ====
// One pixel per cycle at most, no back-pressure; WIDTH and HEIGHT must be even and within 64x64
`default_nettype none

module seg_top #(
    parameter int WIDTH  = 16,
    parameter int HEIGHT = 8
) (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      pixel_valid,
    input  wire seg_score_pkg::score_vec_t pixel_scores,
    input  wire seg_geom_pkg::vcnt_t       pixel_vcnt,
    input  wire seg_geom_pkg::hcnt_t       pixel_hcnt,
    output logic                           label_valid,
    output seg_score_pkg::label_t          label,
    output seg_geom_pkg::vcnt_t            label_vcnt,
    output seg_geom_pkg::hcnt_t            label_hcnt
);

    // ------------------------------
    // Pooling
    // ------------------------------
    logic                      pool_valid;
    seg_score_pkg::score_vec_t pool_scores;
    seg_geom_pkg::vcnt_t       pool_bv;
    seg_geom_pkg::hcnt_t       pool_bh;

    max_pool #(
        .WIDTH  (WIDTH),
        .HEIGHT (HEIGHT)
    ) pool_i (
        .clock        (clock),
        .reset        (reset),
        .pixel_valid  (pixel_valid),
        .pixel_scores (pixel_scores),
        .pixel_vcnt   (pixel_vcnt),
        .pixel_hcnt   (pixel_hcnt),
        .pool_valid   (pool_valid),
        .pool_scores  (pool_scores),
        .pool_bv      (pool_bv),
        .pool_bh      (pool_bh)
    );

    // ------------------------------
    // Class decision per block
    // ------------------------------
    logic                  block_valid;
    seg_score_pkg::label_t block_label;
    seg_geom_pkg::vcnt_t   block_bv;
    seg_geom_pkg::hcnt_t   block_bh;

    class_argmax argmax_i (
        .clock       (clock),
        .reset       (reset),
        .pool_valid  (pool_valid),
        .pool_scores (pool_scores),
        .pool_bv     (pool_bv),
        .pool_bh     (pool_bh),
        .block_valid (block_valid),
        .block_label (block_label),
        .block_bv    (block_bv),
        .block_bh    (block_bh)
    );

    // ------------------------------
    // Unpooling
    // ------------------------------
    label_unpool #(
        .WIDTH  (WIDTH),
        .HEIGHT (HEIGHT)
    ) unpool_i (
        .clock       (clock),
        .reset       (reset),
        .block_valid (block_valid),
        .block_label (block_label),
        .block_bv    (block_bv),
        .block_bh    (block_bh),
        .pixel_valid (pixel_valid),
        .pixel_vcnt  (pixel_vcnt),
        .pixel_hcnt  (pixel_hcnt),
        .label_valid (label_valid),
        .label       (label),
        .label_vcnt  (label_vcnt),
        .label_hcnt  (label_hcnt)
    );

endmodule

`default_nettype wire

// ==== testbench/seg_asserts.sv ====
// Bound to seg_top; the stored-frame flag assumes blocks of a frame arrive in raster order
`default_nettype none

module seg_asserts #(
    parameter int WIDTH  = 16,
    parameter int HEIGHT = 8
) (
    input wire logic                clock,
    input wire logic                reset,
    input wire logic                pool_valid,
    input wire logic                block_valid,
    input wire seg_geom_pkg::vcnt_t block_bv,
    input wire seg_geom_pkg::hcnt_t block_bh,
    input wire logic                label_valid
);

    logic frame_stored;
    int   failures = 0;

    // Set by the last block of the first full frame
    always_ff @(posedge clock) begin
        if (reset) begin
            frame_stored <= 1'b0;
        end else if (block_valid && int'(block_bv) == HEIGHT / 2 - 1 &&
                     int'(block_bh) == WIDTH / 2 - 1) begin
            frame_stored <= 1'b1;
        end
    end

    label_after_prime: assert property (@(posedge clock) disable iff (reset)
        label_valid |-> frame_stored)
        else begin
            $error("label_valid high before a full frame of blocks was stored");
            failures++;
        end

    argmax_latency: assert property (@(posedge clock) disable iff (reset)
        pool_valid |-> ##3 block_valid)
        else begin
            $error("block_valid missing three cycles after pool_valid");
            failures++;
        end

    quiet_after_reset: assert property (@(posedge clock)
        $past(reset) |-> !pool_valid && !block_valid && !label_valid)
        else begin
            $error("valid strobe high after a reset cycle");
            failures++;
        end

endmodule

bind seg_top seg_asserts #(
    .WIDTH  (WIDTH),
    .HEIGHT (HEIGHT)
) asserts_i (
    .clock       (clock),
    .reset       (reset),
    .pool_valid  (pool_valid),
    .block_valid (block_valid),
    .block_bv    (block_bv),
    .block_bh    (block_bh),
    .label_valid (label_valid)
);

`default_nettype wire

// ==== testbench/seg_tb.sv ====
// Runs seg_top at 16x8; labels are one frame late, so each frame is checked against the one before
`default_nettype none

module seg_tb;

    localparam int WIDTH      = 16;
    localparam int HEIGHT     = 8;
    localparam int BW         = WIDTH / 2;
    localparam int BH         = HEIGHT / 2;
    localparam int WAIT_LIMIT = 200;

    logic                      clock = 1'b0;
    logic                      reset;
    logic                      pixel_valid;
    seg_score_pkg::score_vec_t pixel_scores;
    seg_geom_pkg::vcnt_t       pixel_vcnt;
    seg_geom_pkg::hcnt_t       pixel_hcnt;
    logic                      label_valid;
    seg_score_pkg::label_t     label;
    seg_geom_pkg::vcnt_t       label_vcnt;
    seg_geom_pkg::hcnt_t       label_hcnt;

    // Reference model
    seg_score_pkg::score_vec_t frame_px [HEIGHT][WIDTH];
    seg_score_pkg::label_t     prev_labels [BH][BW];
    logic                      model_primed;

    // Expected output driven along with each pixel
    logic                  exp_valid;
    seg_score_pkg::label_t exp_label;
    logic                  chk_valid;
    seg_score_pkg::label_t chk_label;
    seg_geom_pkg::vcnt_t   chk_vcnt;
    seg_geom_pkg::hcnt_t   chk_hcnt;

    logic   monitor_on;
    string  test_name;
    int     check_count;
    int     error_count;
    int     assert_failures;
    int     labels_expected;
    int     labels_seen;
    integer seed;

    seg_top #(
        .WIDTH  (WIDTH),
        .HEIGHT (HEIGHT)
    ) dut_i (
        .clock        (clock),
        .reset        (reset),
        .pixel_valid  (pixel_valid),
        .pixel_scores (pixel_scores),
        .pixel_vcnt   (pixel_vcnt),
        .pixel_hcnt   (pixel_hcnt),
        .label_valid  (label_valid),
        .label        (label),
        .label_vcnt   (label_vcnt),
        .label_hcnt   (label_hcnt)
    );

    always #20 clock = ~clock;

    task automatic compare(input string what, input int expected, input int actual);
        check_count++;
        if (expected != actual) begin
            error_count++;
            $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clock) begin
        if (monitor_on) begin
            compare("label_valid", int'(chk_valid), int'(label_valid));
            if (chk_valid && label_valid) begin
                compare("label", int'(chk_label), int'(label));
                compare("label_vcnt", int'(chk_vcnt), int'(label_vcnt));
                compare("label_hcnt", int'(chk_hcnt), int'(label_hcnt));
                labels_seen++;
            end
        end
        chk_valid = pixel_valid && exp_valid;
        chk_label = exp_label;
        chk_vcnt  = pixel_vcnt;
        chk_hcnt  = pixel_hcnt;
    end

    // Per-channel peak over the block and the highest index among the largest peaks
    function automatic seg_score_pkg::label_t block_label_of(input int bv, input int bh);
        seg_score_pkg::score_t peak [4];
        seg_score_pkg::score_t s;
        int best;
        for (int c = 0; c < 4; c++) begin
            peak[c] = frame_px[2 * bv][2 * bh][c];
            for (int p = 1; p < 4; p++) begin
                s = frame_px[2 * bv + p / 2][2 * bh + p % 2][c];
                if (s > peak[c]) begin
                    peak[c] = s;
                end
            end
        end
        best = 0;
        for (int c = 1; c < 4; c++) begin
            if (peak[c] >= peak[best]) begin
                best = c;
            end
        end
        return seg_score_pkg::label_t'(best);
    endfunction

    task automatic drive_pixel(input int v, input int h);
        @(posedge clock);
        pixel_valid  <= 1'b1;
        pixel_scores <= frame_px[v][h];
        pixel_vcnt   <= seg_geom_pkg::vcnt_t'(v);
        pixel_hcnt   <= seg_geom_pkg::hcnt_t'(h);
        exp_valid    <= model_primed;
        exp_label    <= prev_labels[v / 2][h / 2];
        if (model_primed) begin
            labels_expected++;
        end
    endtask

    // Counters carry no meaning while pixel_valid is low
    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            pixel_valid <= 1'b0;
            pixel_vcnt  <= seg_geom_pkg::vcnt_t'($random(seed));
            pixel_hcnt  <= seg_geom_pkg::hcnt_t'($random(seed));
            exp_valid   <= 1'b0;
        end
    endtask

    task automatic send_frame(input bit with_gaps);
        for (int v = 0; v < HEIGHT; v++) begin
            for (int h = 0; h < WIDTH; h++) begin
                if (with_gaps && ($random(seed) & 3) == 0) begin
                    drive_idle(1 + ($random(seed) & 7));
                end
                drive_pixel(v, h);
            end
        end
        for (int bv = 0; bv < BH; bv++) begin
            for (int bh = 0; bh < BW; bh++) begin
                prev_labels[bv][bh] = block_label_of(bv, bh);
            end
        end
    endtask

    task automatic wait_for_labels();
        int cycles;
        cycles = 0;
        drive_idle(1);
        while (labels_seen < labels_expected && cycles < WAIT_LIMIT) begin
            drive_idle(1);
            cycles++;
        end
        if (labels_seen < labels_expected) begin
            error_count++;
            $display("%s: timed out with only %0d of %0d labels seen",
                     test_name, labels_seen, labels_expected);
        end
    endtask

    // ------------------------------
    // Frame patterns
    // ------------------------------
    task automatic fill_frame(input int kind);
        int bv;
        int bh;
        int mask;
        int base;
        for (int v = 0; v < HEIGHT; v++) begin
            for (int h = 0; h < WIDTH; h++) begin
                bv   = v / 2;
                bh   = h / 2;
                mask = (bv * BW + bh) % 15 + 1;
                base = (bv % 2 == 1) ? -250 : 250;
                for (int c = 0; c < 4; c++) begin
                    case (kind)
                        // Class 2 on top everywhere
                        0: frame_px[v][h][c] = seg_score_pkg::score_t'((c == 2) ? 400 : 100 - 30 * c);
                        // Each channel peaks on its own pixel of the block
                        1: frame_px[v][h][c] = seg_score_pkg::score_t'(
                               ((c + bv + bh) % 4 == (v % 2) * 2 + h % 2) ?
                               100 + ((bv * 3 + bh + c * 5) % 7) * 60 : -300);
                        // Classes in the mask tie at the top
                        2: frame_px[v][h][c] = seg_score_pkg::score_t'(
                               ((mask >> c) & 1) ? base : base - 1 - 2 * c);
                        default: frame_px[v][h][c] = seg_score_pkg::score_t'($random(seed));
                    endcase
                end
            end
        end
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic test_first_frame();
        test_name = "first_frame";
        fill_frame(3);
        send_frame(1'b0);
        // Last block lands in the store 4 cycles after the last pixel
        drive_idle(8);
        model_primed = 1'b1;
    endtask

    task automatic test_two_frames(input string name, input int kind, input bit with_gaps);
        test_name = name;
        fill_frame(kind);
        send_frame(with_gaps);
        fill_frame(kind);
        send_frame(with_gaps);
        wait_for_labels();
    endtask

    task automatic test_random_frames();
        test_name = "random_frames";
        repeat (4) begin
            fill_frame(3);
            send_frame(1'b0);
        end
        wait_for_labels();
    endtask

    initial begin
        seed            = 32'h0e602fe5;
        reset           = 1'b1;
        pixel_valid     = 1'b0;
        pixel_scores    = '0;
        pixel_vcnt      = '0;
        pixel_hcnt      = '0;
        exp_valid       = 1'b0;
        exp_label       = '0;
        monitor_on      = 1'b0;
        model_primed    = 1'b0;
        check_count     = 0;
        error_count     = 0;
        assert_failures = 0;
        labels_expected = 0;
        labels_seen     = 0;
        test_name       = "reset";
        repeat (3) @(posedge clock);
        reset      <= 1'b0;
        monitor_on = 1'b1;

        test_first_frame();
        test_two_frames("uniform", 0, 1'b0);
        test_two_frames("block_maxima", 1, 1'b0);
        test_two_frames("ties", 2, 1'b0);
        test_two_frames("gaps", 3, 1'b1);
        test_random_frames();

        assert_failures = dut_i.asserts_i.failures;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, assert_failures);
        if (error_count == 0 && assert_failures == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
